/* rtl/rv_pkg.sv */
package rv_pkg;

  typedef logic [31:0] word_t;

  // major opcodes in bits [6:0]
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    BRANCH = 7'b1100011,
    SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    PASS_B  // lui
  } alu_op_e;

  // funct3 values
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  // funct7 values
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // addi x0,x0,0
  localparam word_t NOP_INSTR = 32'h0000_0013;

  localparam word_t EBREAK_INSTR = 32'h0010_0073;

  // field positions
  localparam int RD_LSB  = 7;
  localparam int F3_LSB  = 12;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  localparam int F7_LSB  = 25;

endpackage

/* rtl/pipe_if.sv */
`timescale 1ns/100ps

interface dec_ex_if;
  logic            valid;
  rv_pkg::word_t   pc;
  rv_pkg::alu_op_e alu_op;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  rv_pkg::word_t   rs1_data;
  rv_pkg::word_t   rs2_data;
  rv_pkg::word_t   imm;
  logic            use_imm;
  logic [4:0]      rd;
  logic            reg_write;
  logic            is_branch;
  logic            branch_ne;
  logic            halt;

  modport src(output valid, pc, alu_op, rs1, rs2, rs1_data, rs2_data, imm,
              use_imm, rd, reg_write, is_branch, branch_ne, halt);
  modport dst(input valid, pc, alu_op, rs1, rs2, rs1_data, rs2_data, imm,
              use_imm, rd, reg_write, is_branch, branch_ne, halt);
endinterface

`timescale 1ns/100ps

interface ex_res_if;
  logic          valid;
  logic [4:0]    rd;
  rv_pkg::word_t data;
  logic          reg_write;
  logic          halt;

  // execute also reads these back for forwarding
  modport src(output valid, rd, data, reg_write, halt);
  modport dst(input valid, rd, data, reg_write, halt);
endinterface

/* rtl/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit #(
  parameter int IMEM_WORDS = 64
) (
  input  logic                          sys_clk,
  input  logic                          rst,
  input  logic                          start,
  input  logic                          load_we,
  input  logic [$clog2(IMEM_WORDS)-1:0] load_addr,
  input  rv_pkg::word_t                 load_data,
  input  logic                          redirect,
  input  rv_pkg::word_t                 redirect_pc,
  input  logic                          halted,
  output rv_pkg::word_t                 instr,
  output rv_pkg::word_t                 pc,
  output logic                          valid
);

  localparam int AW = $clog2(IMEM_WORDS);

  rv_pkg::word_t imem [IMEM_WORDS];
  rv_pkg::word_t pc_q;

  // program load only before start
  always_ff @(posedge sys_clk) begin
    if (load_we && !start) imem[load_addr] <= load_data;
  end

  always_ff @(posedge sys_clk) begin
    if (rst || !start) begin
      pc_q <= '0;
    end else if (redirect) begin
      pc_q <= redirect_pc;
    end else if (!halted) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      valid <= 1'b0;
      instr <= rv_pkg::NOP_INSTR;
    end else begin
      valid <= start && !redirect && !halted;
      instr <= (redirect || !start) ? rv_pkg::NOP_INSTR : imem[pc_q[AW+1:2]];
    end
  end

  always_ff @(posedge sys_clk) pc <= pc_q;

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
  input  logic          sys_clk,
  input  logic          rst,
  input  rv_pkg::word_t instr,
  input  rv_pkg::word_t pc,
  input  logic          valid,
  input  logic          redirect,
  input  logic          wb_en,
  input  logic [4:0]    wb_rd,
  input  rv_pkg::word_t wb_data,
  dec_ex_if.src         dx
);

  rv_pkg::word_t   regs [1:31];
  rv_pkg::opcode_e opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [4:0]      rs1, rs2, rd;
  rv_pkg::word_t   imm_i, imm_u, imm_b;
  rv_pkg::word_t   rs1_val, rs2_val;

  rv_pkg::alu_op_e alu_op_d, alu_f3;
  rv_pkg::word_t   imm_d;
  logic            f3_ok;
  logic            use_imm_d, reg_write_d, is_branch_d, branch_ne_d, halt_d;

  assign opcode = rv_pkg::opcode_e'(instr[6:0]);
  assign funct3 = instr[rv_pkg::F3_LSB +: 3];
  assign funct7 = instr[rv_pkg::F7_LSB +: 7];
  assign rd     = instr[rv_pkg::RD_LSB +: 5];
  assign rs1    = instr[rv_pkg::RS1_LSB +: 5];
  assign rs2    = instr[rv_pkg::RS2_LSB +: 5];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

  always_ff @(posedge sys_clk) begin
    if (wb_en && wb_rd != 5'd0) regs[wb_rd] <= wb_data;
  end

  // write-through on same-cycle write
  assign rs1_val = (rs1 == 5'd0) ? '0 : (wb_en && wb_rd == rs1) ? wb_data : regs[rs1];
  assign rs2_val = (rs2 == 5'd0) ? '0 : (wb_en && wb_rd == rs2) ? wb_data : regs[rs2];

  // alu op shared by OP and OP_IMM
  always_comb begin
    f3_ok  = 1'b1;
    alu_f3 = rv_pkg::ADD;
    case (funct3)
      rv_pkg::F3_ADD_SUB: alu_f3 = rv_pkg::ADD;
      rv_pkg::F3_SLT:     alu_f3 = rv_pkg::SLT;
      rv_pkg::F3_XOR:     alu_f3 = rv_pkg::XOR;
      rv_pkg::F3_OR:      alu_f3 = rv_pkg::OR;
      rv_pkg::F3_AND:     alu_f3 = rv_pkg::AND;
      default:            f3_ok  = 1'b0;
    endcase
  end

  always_comb begin
    alu_op_d    = alu_f3;
    imm_d       = imm_i;
    use_imm_d   = 1'b0;
    reg_write_d = 1'b0;
    is_branch_d = 1'b0;
    branch_ne_d = 1'b0;
    halt_d      = 1'b0;
    case (opcode)
      rv_pkg::OP: begin
        if (funct7 == rv_pkg::F7_SUB && funct3 == rv_pkg::F3_ADD_SUB) begin
          alu_op_d    = rv_pkg::SUB;
          reg_write_d = 1'b1;
        end else begin
          reg_write_d = f3_ok && funct7 == rv_pkg::F7_BASE;
        end
      end
      rv_pkg::OP_IMM: begin
        use_imm_d   = 1'b1;
        reg_write_d = f3_ok;
      end
      rv_pkg::LUI: begin
        alu_op_d    = rv_pkg::PASS_B;
        imm_d       = imm_u;
        use_imm_d   = 1'b1;
        reg_write_d = 1'b1;
      end
      rv_pkg::BRANCH: begin
        imm_d       = imm_b;
        is_branch_d = funct3 == rv_pkg::F3_BEQ || funct3 == rv_pkg::F3_BNE;
        branch_ne_d = funct3 == rv_pkg::F3_BNE;
      end
      rv_pkg::SYSTEM: halt_d = instr == rv_pkg::EBREAK_INSTR;
      default: ;  // treated as nop
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      dx.valid     <= 1'b0;
      dx.reg_write <= 1'b0;
      dx.is_branch <= 1'b0;
      dx.halt      <= 1'b0;
    end else begin
      dx.valid     <= valid && !redirect;  // flush on taken branch
      dx.reg_write <= reg_write_d;
      dx.is_branch <= is_branch_d;
      dx.halt      <= halt_d;
    end
  end

  always_ff @(posedge sys_clk) begin
    dx.pc        <= pc;
    dx.alu_op    <= alu_op_d;
    dx.rs1       <= rs1;
    dx.rs2       <= rs2;
    dx.rs1_data  <= rs1_val;
    dx.rs2_data  <= rs2_val;
    dx.imm       <= imm_d;
    dx.use_imm   <= use_imm_d;
    dx.rd        <= rd;
    dx.branch_ne <= branch_ne_d;
  end

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
  input  logic          sys_clk,
  input  logic          rst,
  dec_ex_if.dst         dx,
  ex_res_if.src         xr,
  output logic          redirect,
  output rv_pkg::word_t redirect_pc
);

  logic          fwd_ok, fwd1, fwd2;
  rv_pkg::word_t op_a, op_b_reg, op_b;
  rv_pkg::word_t alu_res;
  logic          equal, taken;

  // newest value sits in the result stage register
  assign fwd_ok = xr.valid && xr.reg_write && xr.rd != 5'd0;
  assign fwd1   = fwd_ok && xr.rd == dx.rs1;
  assign fwd2   = fwd_ok && xr.rd == dx.rs2;

  assign op_a     = fwd1 ? xr.data : dx.rs1_data;
  assign op_b_reg = fwd2 ? xr.data : dx.rs2_data;
  assign op_b     = dx.use_imm ? dx.imm : op_b_reg;

  always_comb begin
    case (dx.alu_op)
      rv_pkg::ADD:    alu_res = op_a + op_b;
      rv_pkg::SUB:    alu_res = op_a - op_b;
      rv_pkg::AND:    alu_res = op_a & op_b;
      rv_pkg::OR:     alu_res = op_a | op_b;
      rv_pkg::XOR:    alu_res = op_a ^ op_b;
      rv_pkg::SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_pkg::PASS_B: alu_res = op_b;
      default:        alu_res = '0;
    endcase
  end

  // branch compare always on register operands
  assign equal = op_a == op_b_reg;
  assign taken = dx.is_branch && (dx.branch_ne ? !equal : equal);

  assign redirect    = dx.valid && taken;
  assign redirect_pc = dx.pc + dx.imm;

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      xr.valid     <= 1'b0;
      xr.reg_write <= 1'b0;
      xr.halt      <= 1'b0;
    end else begin
      xr.valid     <= dx.valid;
      xr.reg_write <= dx.reg_write;
      xr.halt      <= dx.halt;
    end
  end

  always_ff @(posedge sys_clk) begin
    xr.rd   <= dx.rd;
    xr.data <= alu_res;
  end

endmodule

/* rtl/result_stage.sv */
`timescale 1ns/100ps

module result_stage (
  input  logic          sys_clk,
  input  logic          rst,
  ex_res_if.dst         xr,
  output logic          wb_en,
  output logic [4:0]    wb_rd,
  output rv_pkg::word_t wb_data,
  output logic          retire_valid,
  output logic [4:0]    retire_rd,
  output rv_pkg::word_t retire_data,
  output logic          halted
);

  logic halted_q;

  // nothing past the ebreak is written
  assign wb_en   = xr.valid && xr.reg_write && xr.rd != 5'd0 && !halted_q;
  assign wb_rd   = xr.rd;
  assign wb_data = xr.data;

  assign retire_valid = wb_en;
  assign retire_rd    = xr.rd;
  assign retire_data  = xr.data;

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      halted_q <= 1'b0;
    end else if (xr.valid && xr.halt) begin
      halted_q <= 1'b1;  // sticky until reset
    end
  end

  assign halted = halted_q;

endmodule

/* rtl/rv_core_top.sv */
`timescale 1ns/100ps

module rv_core_top #(
  parameter int IMEM_WORDS = 64
) (
  input  logic                          sys_clk,
  input  logic                          rst,
  input  logic                          start,
  input  logic                          load_we,
  input  logic [$clog2(IMEM_WORDS)-1:0] load_addr,
  input  rv_pkg::word_t                 load_data,
  output logic                          retire_valid,
  output logic [4:0]                    retire_rd,
  output rv_pkg::word_t                 retire_data,
  output logic                          halted
);

  rv_pkg::word_t instr_fetch;
  rv_pkg::word_t pc_fetch;
  logic          valid_fetch;
  logic          redirect;
  rv_pkg::word_t redirect_pc;
  logic          wb_en;
  logic [4:0]    wb_rd;
  rv_pkg::word_t wb_data;

  dec_ex_if dx ();
  ex_res_if xr ();

  fetch_unit #(
    .IMEM_WORDS(IMEM_WORDS)
  ) fetch_unit_inst (
    .sys_clk(sys_clk), .rst(rst), .start(start),
    .load_we(load_we), .load_addr(load_addr), .load_data(load_data),
    .redirect(redirect), .redirect_pc(redirect_pc), .halted(halted),
    .instr(instr_fetch), .pc(pc_fetch), .valid(valid_fetch)
  );

  decode_stage decode_stage_inst (
    .sys_clk(sys_clk), .rst(rst),
    .instr(instr_fetch), .pc(pc_fetch), .valid(valid_fetch),
    .redirect(redirect),
    .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
    .dx(dx)
  );

  execute_stage execute_stage_inst (
    .sys_clk(sys_clk), .rst(rst), .dx(dx), .xr(xr),
    .redirect(redirect), .redirect_pc(redirect_pc)
  );

  result_stage result_stage_inst (
    .sys_clk(sys_clk), .rst(rst), .xr(xr),
    .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
    .retire_valid(retire_valid), .retire_rd(retire_rd),
    .retire_data(retire_data), .halted(halted)
  );

endmodule

/* sim/rv_checker.sv */
`timescale 1ns/100ps

module rv_checker (
  input logic          sys_clk,
  input logic          rst,
  input logic          retire_valid,
  input logic [4:0]    retire_rd,
  input rv_pkg::word_t retire_data,
  input logic          halted
);

  logic [36:0] exp_q [$];  // {rd, data}
  logic [36:0] exp_item;
  string       test_name;
  int          test_errors;
  int          retires;
  int          error_count = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic        halted_seen;

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    retires     = 0;
    exp_q.delete();
  endtask

  task automatic add_expected(input logic [4:0] rd, input rv_pkg::word_t data);
    exp_q.push_back({rd, data});
  endtask

  task automatic count_error();
    test_errors++;
    error_count++;
  endtask

  task automatic print_summary();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
  endtask

  always @(posedge sys_clk) begin
    if (rst) begin
      halted_seen <= 1'b0;
    end else begin
      if (retire_valid) begin
        retires++;
        if (exp_q.size() == 0) begin
          $display("%0t: unexpected retire of x%0d in %s", $time, retire_rd, test_name);
          count_error();
        end else begin
          exp_item = exp_q.pop_front();
          if (retire_rd !== exp_item[36:32]) begin
            $display("Mismatch at %0t: retire_rd expected %0d actual %0d",
                     $time, exp_item[36:32], retire_rd);
            count_error();
          end
          if (retire_data !== exp_item[31:0]) begin
            $display("Mismatch at %0t: retire_data expected %h actual %h",
                     $time, exp_item[31:0], retire_data);
            count_error();
          end
        end
      end
      if (halted && !halted_seen) begin  // end of one program
        if (exp_q.size() != 0) begin
          $display("%0t: missing retires, %0d writes never seen in %s",
                   $time, exp_q.size(), test_name);
          count_error();
        end
        tests_run++;
        if (test_errors != 0) tests_failed++;
        $display("test %s: %s, %0d retires, %0d errors", test_name,
                 (test_errors == 0) ? "ok" : "failed", retires, test_errors);
      end
      halted_seen <= halted;
    end
  end

endmodule

/* sim/tb_top.sv */
`timescale 1ns/100ps

module tb_top;

  localparam int IMEM_WORDS = 64;
  localparam logic [2:0] F_ADD = 3'd0;
  localparam logic [2:0] F_SLT = 3'd2;
  localparam logic [2:0] F_XOR = 3'd4;
  localparam logic [2:0] F_OR  = 3'd6;
  localparam logic [2:0] F_AND = 3'd7;
  localparam logic [6:0] F7_ADD = 7'h00;
  localparam logic [6:0] F7_SUB = 7'h20;
  localparam rv_pkg::word_t EBREAK = 32'h0010_0073;

  logic          sys_clk = 1'b0;
  logic          rst;
  logic          start;
  logic          load_we;
  logic [5:0]    load_addr;
  rv_pkg::word_t load_data;
  logic          retire_valid;
  logic [4:0]    retire_rd;
  rv_pkg::word_t retire_data;
  logic          halted;

  rv_pkg::word_t prog [IMEM_WORDS];
  int            prog_len;
  logic [15:0]   lfsr = 16'd94;
  int            cycle_count = 0;
  int            cycle_limit = 0;

  rv_core_top #(.IMEM_WORDS(IMEM_WORDS)) rv_core_top_inst (
    .sys_clk(sys_clk), .rst(rst), .start(start), .load_we(load_we),
    .load_addr(load_addr), .load_data(load_data), .retire_valid(retire_valid),
    .retire_rd(retire_rd), .retire_data(retire_data), .halted(halted)
  );

  rv_checker checker_inst (
    .sys_clk(sys_clk), .rst(rst), .retire_valid(retire_valid),
    .retire_rd(retire_rd), .retire_data(retire_data), .halted(halted)
  );

  always #2 sys_clk = ~sys_clk;

  // budget only counts cycles with the core running
  always @(posedge sys_clk) begin
    if (start) cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: core did not halt within %0d run cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rv_pkg::word_t enc_i(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic rv_pkg::word_t enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic rv_pkg::word_t enc_b(input logic ne, input logic [4:0] rs1, rs2,
                                          input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], 7'b1100011};
  endfunction

  // expected ALU value from the ISA definitions
  function automatic rv_pkg::word_t ref_alu(input logic [2:0] f3, input logic sub,
                                            input rv_pkg::word_t a, b);
    case (f3)
      3'd0:    return sub ? a - b : a + b;
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic append_instr(input rv_pkg::word_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  // unused words become addi x0,x0,<address>
  task automatic new_program();
    for (int a = 0; a < IMEM_WORDS; a++) prog[a] = enc_i(F_ADD, 5'd0, 5'd0, 12'(a));
    prog_len = 0;
  endtask

  task automatic init_regs();
    for (int r = 1; r < 8; r++) append_instr(enc_i(F_ADD, 5'(r), 5'd0, 12'(take_bits(12))));
  endtask

  // ISA level walk of the program up to ebreak
  task automatic run_reference(output int executed);
    rv_pkg::word_t regs [32];
    rv_pkg::word_t ins;
    rv_pkg::word_t val;
    rv_pkg::word_t b_off;
    int            idx;
    logic          wr;
    for (int r = 0; r < 32; r++) regs[r] = '0;
    idx = 0;
    executed = 0;
    while (idx >= 0 && idx < IMEM_WORDS && executed < 400) begin
      ins = prog[idx];
      executed++;
      if (ins == EBREAK) break;
      wr = 1'b0;
      val = '0;
      idx++;
      case (ins[6:0])
        7'b0110011: begin
          wr  = 1'b1;
          val = ref_alu(ins[14:12], ins[30], regs[ins[19:15]], regs[ins[24:20]]);
        end
        7'b0010011: begin
          wr  = 1'b1;
          val = ref_alu(ins[14:12], 1'b0, regs[ins[19:15]], {{20{ins[31]}}, ins[31:20]});
        end
        7'b0110111: begin
          wr  = 1'b1;
          val = {ins[31:12], 12'h000};
        end
        7'b1100011: begin
          b_off = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
          if ((regs[ins[19:15]] == regs[ins[24:20]]) ^ ins[12])
            idx = idx - 1 + int'($signed(b_off)) / 4;
        end
        default: ;
      endcase
      if (wr && ins[11:7] != 5'd0) begin
        regs[ins[11:7]] = val;
        checker_inst.add_expected(ins[11:7], val);
      end
    end
  endtask

  task automatic run_test(input string name);
    int executed;
    checker_inst.start_test(name);
    run_reference(executed);
    cycle_limit = cycle_limit + 20 + 3 * executed;
    rst   = 1'b1;
    start = 1'b0;
    repeat (4) @(posedge sys_clk);
    #0.5 rst = 1'b0;
    for (int a = 0; a < IMEM_WORDS; a++) begin
      load_we   = 1'b1;
      load_addr = 6'(a);
      load_data = prog[a];
      @(posedge sys_clk);
      #0.5;
    end
    load_we = 1'b0;
    start   = 1'b1;
    while (!halted) @(posedge sys_clk);
    repeat (4) @(posedge sys_clk);  // nothing may retire past the halt
    #0.5 start = 1'b0;
  endtask

  initial begin
    logic [2:0] kind;
    logic [4:0] rd, rs1, rs2;
    rst = 1'b1;
    start = 1'b0;
    load_we = 1'b0;
    load_addr = '0;
    load_data = '0;
    @(posedge sys_clk);
    #0.5;

    new_program();
    init_regs();
    append_instr(enc_lui(5'd4, 20'h80000));  // negative operand for slt
    append_instr(enc_r(F7_ADD, F_ADD, 5'd1, 5'd2, 5'd3));
    append_instr(enc_r(F7_SUB, F_ADD, 5'd5, 5'd1, 5'd6));
    append_instr(enc_r(F7_ADD, F_AND, 5'd6, 5'd1, 5'd7));
    append_instr(enc_r(F7_ADD, F_OR, 5'd7, 5'd5, 5'd2));
    append_instr(enc_r(F7_ADD, F_XOR, 5'd2, 5'd7, 5'd3));
    append_instr(enc_r(F7_ADD, F_SLT, 5'd3, 5'd4, 5'd1));
    append_instr(enc_r(F7_ADD, F_SLT, 5'd1, 5'd1, 5'd4));
    append_instr(EBREAK);
    run_test("alu_reg");

    new_program();
    append_instr(enc_i(F_ADD, 5'd1, 5'd0, 12'hffb));  // -5
    append_instr(enc_i(F_AND, 5'd2, 5'd1, 12'h0f0));
    append_instr(enc_i(F_OR, 5'd3, 5'd1, 12'hf00));
    append_instr(enc_i(F_XOR, 5'd4, 5'd1, 12'hfff));
    append_instr(enc_i(F_SLT, 5'd5, 5'd1, 12'hffc));
    append_instr(enc_i(F_SLT, 5'd6, 5'd1, 12'hffa));
    append_instr(enc_lui(5'd7, 20'hfedcb));
    append_instr(enc_i(F_ADD, 5'd7, 5'd7, 12'h800));
    append_instr(enc_i(F_ADD, 5'd0, 5'd1, 12'h007));  // x0 writes
    append_instr(enc_lui(5'd0, 20'h12345));
    append_instr(enc_r(F7_ADD, F_ADD, 5'd2, 5'd0, 5'd7));
    append_instr(EBREAK);
    run_test("alu_imm");

    new_program();
    append_instr(enc_i(F_ADD, 5'd1, 5'd0, 12'h00a));
    append_instr(enc_i(F_ADD, 5'd2, 5'd1, 12'h003));        // distance 1
    append_instr(enc_i(F_XOR, 5'd3, 5'd1, 12'h0ff));        // distance 2
    append_instr(enc_r(F7_ADD, F_ADD, 5'd4, 5'd1, 5'd2));   // distance 3 and 2
    append_instr(enc_r(F7_SUB, F_ADD, 5'd5, 5'd4, 5'd3));
    append_instr(enc_r(F7_ADD, F_ADD, 5'd5, 5'd5, 5'd5));
    append_instr(enc_r(F7_ADD, F_OR, 5'd6, 5'd5, 5'd4));
    append_instr(enc_r(F7_ADD, F_SLT, 5'd7, 5'd6, 5'd5));
    append_instr(EBREAK);
    run_test("forwarding");

    new_program();
    append_instr(enc_i(F_ADD, 5'd1, 5'd0, 12'h005));  // loop count
    append_instr(enc_i(F_ADD, 5'd2, 5'd0, 12'h000));
    append_instr(enc_r(F7_ADD, F_ADD, 5'd2, 5'd2, 5'd1));
    append_instr(enc_i(F_ADD, 5'd1, 5'd1, 12'hfff));
    append_instr(enc_b(1'b1, 5'd1, 5'd0, 13'h1ff8));  // back to the add
    append_instr(enc_b(1'b0, 5'd2, 5'd0, 13'd8));     // not taken
    append_instr(enc_i(F_ADD, 5'd3, 5'd0, 12'h00b));
    append_instr(enc_b(1'b0, 5'd1, 5'd0, 13'd12));    // taken
    append_instr(enc_i(F_ADD, 5'd4, 5'd0, 12'h063));
    append_instr(enc_i(F_ADD, 5'd5, 5'd0, 12'h062));
    append_instr(enc_b(1'b1, 5'd3, 5'd3, 13'd8));
    append_instr(enc_i(F_ADD, 5'd6, 5'd2, 12'h001));
    append_instr(EBREAK);
    run_test("branch");

    new_program();
    init_regs();
    for (int i = 0; i < 40; i++) begin
      kind = 3'(take_bits(3));
      rd   = 5'(1 + take_bits(3) % 7);
      rs1  = 5'(1 + take_bits(3) % 7);
      rs2  = 5'(1 + take_bits(3) % 7);
      case (kind)
        3'd0: append_instr(enc_r(F7_ADD, F_ADD, rd, rs1, rs2));
        3'd1: append_instr(enc_r(F7_SUB, F_ADD, rd, rs1, rs2));
        3'd2: append_instr(enc_r(F7_ADD, F_AND, rd, rs1, rs2));
        3'd3: append_instr(enc_r(F7_ADD, F_OR, rd, rs1, rs2));
        3'd4: append_instr(enc_r(F7_ADD, F_XOR, rd, rs1, rs2));
        3'd5: append_instr(enc_r(F7_ADD, F_SLT, rd, rs1, rs2));
        3'd6: append_instr(enc_i(F_ADD, rd, rs1, 12'(take_bits(12))));
        default: append_instr(enc_i(F_SLT, rd, rs1, 12'(take_bits(12))));
      endcase
    end
    append_instr(EBREAK);
    run_test("random");

    new_program();
    append_instr(enc_i(F_ADD, 5'd1, 5'd0, 12'h021));
    append_instr(enc_r(F7_ADD, F_ADD, 5'd2, 5'd1, 5'd1));
    append_instr(EBREAK);
    append_instr(enc_i(F_ADD, 5'd3, 5'd0, 12'h04d));  // never executed
    append_instr(enc_r(F7_ADD, F_OR, 5'd1, 5'd2, 5'd2));
    append_instr(enc_lui(5'd2, 20'h0dead));
    run_test("halt");

    repeat (2) @(posedge sys_clk);
    checker_inst.print_summary();
    if (checker_inst.error_count == 0 && checker_inst.tests_run == 6) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
rtl/rv_pkg.sv
rtl/pipe_if.sv
rtl/fetch_unit.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/rv_core_top.sv
sim/rv_checker.sv
sim/tb_top.sv

/* Makefile */
SIM = obj_dir/Vtb_top
SRCS = $(filter-out +%,$(shell cat sources.f))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): sources.f $(SRCS)
	verilator --binary --timing --timescale 1ns/100ps --top-module tb_top \
		-f sources.f -o Vtb_top

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
